// ==== verilog/hyperx_pkg.sv ====
`default_nettype none

package hyperx_pkg;

    localparam int V_ID_WIDTH = 16;
    localparam int V_VALUE_WIDTH = 32;

    // 2 x 4 grid, core index = row * COL_NUM + col
    localparam int ROW_NUM = 2;
    localparam int COL_NUM = 4;
    localparam int CORE_NUM = ROW_NUM * COL_NUM;

    // id bits 1..0 pick the column, bit 2 picks the row
    localparam int COL_FIELD_LSB = 0;
    localparam int COL_FIELD_WIDTH = 2;
    localparam int ROW_FIELD_LSB = COL_FIELD_LSB + COL_FIELD_WIDTH;
    localparam int ROW_FIELD_WIDTH = 1;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_ALMOST_FULL = 6;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef struct packed {
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
    } vertex_upd_t;

    // which id field a crossbar decodes
    typedef enum logic {
        ROUTE_ROW,
        ROUTE_COL
    } route_field_e;

endpackage

`default_nettype wire

// ==== verilog/vertex_fifo.sv ====
`default_nettype none

module vertex_fifo (
    input  wire                      clk,
    input  wire                      rst,
    input  hyperx_pkg::vertex_upd_t  din,
    input  wire                      wr_en,
    input  wire                      rd_en,
    output hyperx_pkg::vertex_upd_t  dout,
    output logic                     valid,
    output logic                     empty,
    output logic                     almost_full
);

    hyperx_pkg::vertex_upd_t mem [hyperx_pkg::FIFO_DEPTH];

    logic [hyperx_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [hyperx_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [hyperx_pkg::FIFO_CNT_WIDTH-1:0] count;
    logic                                  do_wr;
    logic                                  do_rd;

    assign empty = (count == '0);
    assign valid = !empty;
    assign almost_full = (count >= hyperx_pkg::FIFO_CNT_WIDTH'(hyperx_pkg::FIFO_ALMOST_FULL));

    // head is always visible, a read just advances the pointer
    assign dout = mem[rd_ptr];

    assign do_rd = rd_en && !empty;
    // a full buffer still accepts a write if a read frees a slot
    assign do_wr = wr_en &&
                   ((count != hyperx_pkg::FIFO_CNT_WIDTH'(hyperx_pkg::FIFO_DEPTH)) || do_rd);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rr_crossbar.sv ====
`default_nettype none

module rr_crossbar #(
    parameter int                       PORTS = 4,
    parameter hyperx_pkg::route_field_e FIELD = hyperx_pkg::ROUTE_COL
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  hyperx_pkg::vertex_upd_t [PORTS-1:0]  req_upd,
    input  wire [PORTS-1:0]                      req_valid,
    input  wire [PORTS-1:0]                      dest_full,
    output logic [PORTS-1:0]                     read,
    output hyperx_pkg::vertex_upd_t [PORTS-1:0]  out_upd,
    output logic [PORTS-1:0]                     out_valid
);

    localparam int FIELD_LSB = (FIELD == hyperx_pkg::ROUTE_ROW) ?
                               hyperx_pkg::ROW_FIELD_LSB : hyperx_pkg::COL_FIELD_LSB;
    localparam int FIELD_W = (FIELD == hyperx_pkg::ROUTE_ROW) ?
                             hyperx_pkg::ROW_FIELD_WIDTH : hyperx_pkg::COL_FIELD_WIDTH;

    logic [FIELD_W-1:0] req_dest [PORTS];
    // req[p][s]: source s wants output p and p has room
    logic [PORTS-1:0]   req [PORTS];
    wire  [PORTS-1:0]   gnt [PORTS];
    logic [PORTS-1:0]   prio;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= PORTS'(1);
        end else begin
            prio <= {prio[PORTS-2:0], prio[PORTS-1]};
        end
    end

    always_comb begin
        for (int s = 0; s < PORTS; s++) begin
            req_dest[s] = req_upd[s].id[FIELD_LSB +: FIELD_W];
        end
        for (int p = 0; p < PORTS; p++) begin
            for (int s = 0; s < PORTS; s++) begin
                req[p][s] = req_valid[s] && (req_dest[s] == FIELD_W'(p)) && !dest_full[p];
            end
        end
    end

    // first requester at or after the priority bit, wrapping around
    for (genvar p = 0; p < PORTS; p++) begin : g_arb
        logic [2*PORTS-1:0] dbl_req;
        logic [2*PORTS-1:0] dbl_gnt;

        assign dbl_req = {req[p], req[p]};
        assign dbl_gnt = dbl_req & ~(dbl_req - {{PORTS{1'b0}}, prio});
        assign gnt[p] = dbl_gnt[2*PORTS-1:PORTS] | dbl_gnt[PORTS-1:0];
    end

    // a source only ever targets one output, so it is popped at most once
    always_comb begin
        read = '0;
        for (int p = 0; p < PORTS; p++) begin
            out_upd[p] = '0;
            out_valid[p] = |gnt[p];
            for (int s = 0; s < PORTS; s++) begin
                if (gnt[p][s]) begin
                    out_upd[p] = req_upd[s];
                    read[s] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hyperx_node.sv ====
`default_nettype none

module hyperx_node (
    input  wire                      clk,
    input  wire                      rst,
    input  hyperx_pkg::vertex_upd_t  front_upd,
    input  wire                      front_valid,
    input  wire                      front_iteration_end,
    input  wire                      dest_full,
    input  wire                      row_read,
    input  hyperx_pkg::vertex_upd_t  row_in_upd,
    input  wire                      row_in_valid,
    input  wire                      col_read,
    input  hyperx_pkg::vertex_upd_t  col_in_upd,
    input  wire                      col_in_valid,
    output hyperx_pkg::vertex_upd_t  row_upd,
    output wire                      row_valid,
    output hyperx_pkg::vertex_upd_t  col_upd,
    output wire                      col_valid,
    output wire                      col_full,
    output wire                      upd_full,
    output hyperx_pkg::vertex_upd_t  upd,
    output wire                      upd_valid,
    output logic                     iteration_end,
    output wire                      stage_full
);

    wire  row_empty;
    wire  col_empty;
    wire  upd_empty;
    wire  upd_head_valid;
    wire  drained;
    logic drained_q;

    // core input, popped by the row crossbar
    vertex_fifo u_row_fifo (
        .clk         (clk),
        .rst         (rst),
        .din         (front_upd),
        .wr_en       (front_valid),
        .rd_en       (row_read),
        .dout        (row_upd),
        .valid       (row_valid),
        .empty       (row_empty),
        .almost_full (stage_full)
    );

    // filled by the row crossbar, popped by the column crossbar
    vertex_fifo u_col_fifo (
        .clk         (clk),
        .rst         (rst),
        .din         (row_in_upd),
        .wr_en       (row_in_valid),
        .rd_en       (col_read),
        .dout        (col_upd),
        .valid       (col_valid),
        .empty       (col_empty),
        .almost_full (col_full)
    );

    vertex_fifo u_upd_fifo (
        .clk         (clk),
        .rst         (rst),
        .din         (col_in_upd),
        .wr_en       (col_in_valid),
        .rd_en       (!dest_full),
        .dout        (upd),
        .valid       (upd_head_valid),
        .empty       (upd_empty),
        .almost_full (upd_full)
    );

    // the head leaves whenever the core can take it
    assign upd_valid = upd_head_valid && !dest_full;

    assign drained = front_iteration_end && !front_valid &&
                     row_empty && col_empty && upd_empty;

    // one pulse on the first drained cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            drained_q     <= 1'b0;
            iteration_end <= 1'b0;
        end else begin
            drained_q     <= drained;
            iteration_end <= drained && !drained_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hyperx_net.sv ====
`default_nettype none

module hyperx_net (
    input  wire                                                 clk,
    input  wire                                                 rst,
    input  hyperx_pkg::vertex_upd_t [hyperx_pkg::CORE_NUM-1:0]  front_upd,
    input  wire [hyperx_pkg::CORE_NUM-1:0]                      front_valid,
    input  wire [hyperx_pkg::CORE_NUM-1:0]                      front_iteration_end,
    input  wire [hyperx_pkg::CORE_NUM-1:0]                      dest_full,
    output wire hyperx_pkg::vertex_upd_t [hyperx_pkg::CORE_NUM-1:0] upd,
    output wire [hyperx_pkg::CORE_NUM-1:0]                      upd_valid,
    output wire [hyperx_pkg::CORE_NUM-1:0]                      iteration_end,
    output wire [hyperx_pkg::CORE_NUM-1:0]                      stage_full
);

    // row crossbar side, one set per grid column, indexed by row
    wire hyperx_pkg::vertex_upd_t [hyperx_pkg::ROW_NUM-1:0] rx_req_upd [hyperx_pkg::COL_NUM];
    wire [hyperx_pkg::ROW_NUM-1:0] rx_req_valid [hyperx_pkg::COL_NUM];
    wire [hyperx_pkg::ROW_NUM-1:0] rx_full [hyperx_pkg::COL_NUM];
    wire [hyperx_pkg::ROW_NUM-1:0] rx_read [hyperx_pkg::COL_NUM];
    wire hyperx_pkg::vertex_upd_t [hyperx_pkg::ROW_NUM-1:0] rx_out_upd [hyperx_pkg::COL_NUM];
    wire [hyperx_pkg::ROW_NUM-1:0] rx_out_valid [hyperx_pkg::COL_NUM];

    // column crossbar side, one set per grid row, indexed by column
    wire hyperx_pkg::vertex_upd_t [hyperx_pkg::COL_NUM-1:0] cx_req_upd [hyperx_pkg::ROW_NUM];
    wire [hyperx_pkg::COL_NUM-1:0] cx_req_valid [hyperx_pkg::ROW_NUM];
    wire [hyperx_pkg::COL_NUM-1:0] cx_full [hyperx_pkg::ROW_NUM];
    wire [hyperx_pkg::COL_NUM-1:0] cx_read [hyperx_pkg::ROW_NUM];
    wire hyperx_pkg::vertex_upd_t [hyperx_pkg::COL_NUM-1:0] cx_out_upd [hyperx_pkg::ROW_NUM];
    wire [hyperx_pkg::COL_NUM-1:0] cx_out_valid [hyperx_pkg::ROW_NUM];

    for (genvar j = 0; j < hyperx_pkg::COL_NUM; j++) begin : g_row_xbar
        rr_crossbar #(
            .PORTS (hyperx_pkg::ROW_NUM),
            .FIELD (hyperx_pkg::ROUTE_ROW)
        ) u_row_xbar (
            .clk       (clk),
            .rst       (rst),
            .req_upd   (rx_req_upd[j]),
            .req_valid (rx_req_valid[j]),
            .dest_full (rx_full[j]),
            .read      (rx_read[j]),
            .out_upd   (rx_out_upd[j]),
            .out_valid (rx_out_valid[j])
        );
    end

    for (genvar i = 0; i < hyperx_pkg::ROW_NUM; i++) begin : g_col_xbar
        rr_crossbar #(
            .PORTS (hyperx_pkg::COL_NUM),
            .FIELD (hyperx_pkg::ROUTE_COL)
        ) u_col_xbar (
            .clk       (clk),
            .rst       (rst),
            .req_upd   (cx_req_upd[i]),
            .req_valid (cx_req_valid[i]),
            .dest_full (cx_full[i]),
            .read      (cx_read[i]),
            .out_upd   (cx_out_upd[i]),
            .out_valid (cx_out_valid[i])
        );
    end

    for (genvar i = 0; i < hyperx_pkg::ROW_NUM; i++) begin : g_row
        for (genvar j = 0; j < hyperx_pkg::COL_NUM; j++) begin : g_col
            localparam int C = i * hyperx_pkg::COL_NUM + j;

            hyperx_node u_node (
                .clk                 (clk),
                .rst                 (rst),
                .front_upd           (front_upd[C]),
                .front_valid         (front_valid[C]),
                .front_iteration_end (front_iteration_end[C]),
                .dest_full           (dest_full[C]),
                .row_read            (rx_read[j][i]),
                .row_in_upd          (rx_out_upd[j][i]),
                .row_in_valid        (rx_out_valid[j][i]),
                .col_read            (cx_read[i][j]),
                .col_in_upd          (cx_out_upd[i][j]),
                .col_in_valid        (cx_out_valid[i][j]),
                .row_upd             (rx_req_upd[j][i]),
                .row_valid           (rx_req_valid[j][i]),
                .col_upd             (cx_req_upd[i][j]),
                .col_valid           (cx_req_valid[i][j]),
                .col_full            (rx_full[j][i]),
                .upd_full            (cx_full[i][j]),
                .upd                 (upd[C]),
                .upd_valid           (upd_valid[C]),
                .iteration_end       (iteration_end[C]),
                .stage_full          (stage_full[C])
            );
        end
    end

endmodule

`default_nettype wire

// ==== verif/hyperx_net_tb.sv ====
`default_nettype none

module hyperx_net_tb;

    localparam int TIMEOUT = 2000;
    localparam int MAX_REC = 128;
    localparam int FLOOD_DST = 6;
    localparam int HOLD_CORE = 3;
    localparam int IDLE_CORE = 0;

    logic clk = 1'b0;
    logic rst;
    hyperx_pkg::vertex_upd_t [hyperx_pkg::CORE_NUM-1:0] front_upd;
    logic [hyperx_pkg::CORE_NUM-1:0] front_valid;
    logic [hyperx_pkg::CORE_NUM-1:0] front_iteration_end;
    logic [hyperx_pkg::CORE_NUM-1:0] dest_full;
    wire hyperx_pkg::vertex_upd_t [hyperx_pkg::CORE_NUM-1:0] upd;
    wire [hyperx_pkg::CORE_NUM-1:0] upd_valid;
    wire [hyperx_pkg::CORE_NUM-1:0] iteration_end;
    wire [hyperx_pkg::CORE_NUM-1:0] stage_full;

    // five words per record
    logic [31:0] gold [5*MAX_REC];
    int nrec;
    hyperx_pkg::vertex_upd_t exp_q [hyperx_pkg::CORE_NUM][$];
    int ite_cnt [hyperx_pkg::CORE_NUM];
    int mism_cnt;
    int fail_cnt;
    int timeout_cnt;
    logic release_on_full;
    logic saw_full;

    always #20 clk = ~clk;

    hyperx_net u_hyperx_net (
        .clk                 (clk),
        .rst                 (rst),
        .front_upd           (front_upd),
        .front_valid         (front_valid),
        .front_iteration_end (front_iteration_end),
        .dest_full           (dest_full),
        .upd                 (upd),
        .upd_valid           (upd_valid),
        .iteration_end       (iteration_end),
        .stage_full          (stage_full)
    );

    // destination core = row field (id bit 2) * 4 + column field (id bits 1..0)
    function automatic int dest_of_id(input logic [15:0] id);
        return int'(id[2]) * hyperx_pkg::COL_NUM + int'(id[1:0]);
    endfunction

    function automatic int pending();
        int total;
        total = 0;
        for (int c = 0; c < hyperx_pkg::CORE_NUM; c++) begin
            total += exp_q[c].size();
        end
        return total;
    endfunction

    // oldest outstanding update from the same source must match
    task automatic check_arrival(input int c, input hyperx_pkg::vertex_upd_t got);
        int k;
        k = -1;
        for (int n = 0; n < exp_q[c].size(); n++) begin
            if (k < 0 && exp_q[c][n].value[31:24] == got.value[31:24]) begin
                k = n;
            end
        end
        if (k < 0) begin
            fail_cnt++;
            $display("unexpected update at core %0d: id %h value %h", c, got.id, got.value);
        end else begin
            if (exp_q[c][k].id !== got.id) begin
                mism_cnt++;
                $display("MISMATCH upd[%0d].id exp %h got %h", c, exp_q[c][k].id, got.id);
            end
            if (exp_q[c][k].value !== got.value) begin
                mism_cnt++;
                $display("MISMATCH upd[%0d].value exp %h got %h", c, exp_q[c][k].value,
                         got.value);
            end
            exp_q[c].delete(k);
        end
    endtask

    task automatic watch_outputs();
        forever begin
            @(posedge clk);
            if ((upd_valid & dest_full) !== '0) begin
                mism_cnt++;
                $display("MISMATCH upd_valid on held cores exp %h got %h", 8'h00,
                         upd_valid & dest_full);
            end
            for (int c = 0; c < hyperx_pkg::CORE_NUM; c++) begin
                if (iteration_end[c]) begin
                    ite_cnt[c]++;
                end
                if (upd_valid[c]) begin
                    check_arrival(c, upd[c]);
                end
            end
        end
    endtask

    task automatic wait_room(input logic [7:0] mask);
        int n;
        n = 0;
        @(negedge clk);
        front_valid = '0;
        while ((stage_full & mask) != '0 && n < TIMEOUT) begin
            if (release_on_full) begin
                // flood has backed up to the source so the core may drain
                saw_full = 1'b1;
                release_on_full = 1'b0;
                dest_full = '0;
            end
            @(negedge clk);
            n++;
        end
        if ((stage_full & mask) != '0) begin
            timeout_cnt++;
            $display("timeout: stage_full stuck high at sources %h", stage_full & mask);
        end
    endtask

    task automatic run_phase(input int phase);
        int i;
        int j;
        int d;
        logic [7:0] mask;
        hyperx_pkg::vertex_upd_t u;
        i = 0;
        while (i < nrec) begin
            if (gold[5*i] != phase) begin
                i++;
            end else begin
                // one beat is a run of records from distinct sources
                mask = '0;
                j = i;
                while (j < nrec && gold[5*j] == phase && !mask[gold[5*j+1][2:0]]) begin
                    mask[gold[5*j+1][2:0]] = 1'b1;
                    j++;
                end
                wait_room(mask);
                while (i < j) begin
                    u.id = gold[5*i+2][15:0];
                    u.value = gold[5*i+3];
                    d = dest_of_id(u.id);
                    if (d != gold[5*i+4]) begin
                        mism_cnt++;
                        $display("MISMATCH golden dest of id %h exp %h got %h", u.id, d,
                                 gold[5*i+4]);
                    end
                    front_upd[gold[5*i+1][2:0]] = u;
                    front_valid[gold[5*i+1][2:0]] = 1'b1;
                    exp_q[d].push_back(u);
                    i++;
                end
            end
        end
        @(negedge clk);
        front_valid = '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending() != 0) begin
            timeout_cnt++;
            $display("timeout: %0d updates never delivered", pending());
        end
    endtask

    task automatic wait_pulse(input int c);
        int n;
        n = 0;
        while (ite_cnt[c] == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ite_cnt[c] == 0) begin
            timeout_cnt++;
            $display("timeout: no iteration_end pulse at core %0d", c);
        end
    endtask

    initial begin
        int exp_pulses;
        rst = 1'b1;
        front_upd = '0;
        front_valid = '0;
        front_iteration_end = '0;
        dest_full = '0;
        mism_cnt = 0;
        fail_cnt = 0;
        timeout_cnt = 0;
        release_on_full = 1'b0;
        saw_full = 1'b0;
        for (int c = 0; c < hyperx_pkg::CORE_NUM; c++) begin
            ite_cnt[c] = 0;
        end
        $readmemh("verif/hyperx_net_golden.txt", gold);
        nrec = 0;
        while (nrec < MAX_REC && gold[5*nrec] !== 32'hf && !$isunknown(gold[5*nrec])) begin
            nrec++;
        end
        if (nrec == 0) begin
            fail_cnt++;
            $display("golden file holds no records");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            watch_outputs();
        join_none
        @(negedge clk);
        if (upd_valid !== '0) begin
            mism_cnt++;
            $display("MISMATCH upd_valid exp %h got %h", 8'h00, upd_valid);
        end
        if (iteration_end !== '0) begin
            mism_cnt++;
            $display("MISMATCH iteration_end exp %h got %h", 8'h00, iteration_end);
        end
        if (stage_full !== '0) begin
            mism_cnt++;
            $display("MISMATCH stage_full exp %h got %h", 8'h00, stage_full);
        end

        // every source to every core and then all sources into one core
        run_phase(1);
        wait_drain();
        run_phase(2);
        wait_drain();

        @(negedge clk);
        dest_full[FLOOD_DST] = 1'b1;
        release_on_full = 1'b1;
        run_phase(3);
        if (!saw_full) begin
            fail_cnt++;
            $display("stage_full of the flooding source never rose");
            release_on_full = 1'b0;
            dest_full = '0;
        end
        wait_drain();

        // updates parked in the held core's update buffer
        @(negedge clk);
        dest_full[HOLD_CORE] = 1'b1;
        run_phase(4);
        front_iteration_end[HOLD_CORE] = 1'b1;
        repeat (20) @(negedge clk);
        if (ite_cnt[HOLD_CORE] != 0) begin
            mism_cnt++;
            $display("MISMATCH iteration_end[%0d] pulses before drain exp %h got %h",
                     HOLD_CORE, 0, ite_cnt[HOLD_CORE]);
        end
        dest_full[HOLD_CORE] = 1'b0;
        wait_drain();
        wait_pulse(HOLD_CORE);
        repeat (10) @(negedge clk);
        front_iteration_end[HOLD_CORE] = 1'b0;
        front_iteration_end[IDLE_CORE] = 1'b1;
        wait_pulse(IDLE_CORE);
        repeat (10) @(negedge clk);
        front_iteration_end[IDLE_CORE] = 1'b0;
        @(negedge clk);
        for (int c = 0; c < hyperx_pkg::CORE_NUM; c++) begin
            exp_pulses = (c == HOLD_CORE || c == IDLE_CORE) ? 1 : 0;
            if (ite_cnt[c] != exp_pulses) begin
                mism_cnt++;
                $display("MISMATCH iteration_end[%0d] pulses exp %h got %h", c, exp_pulses,
                         ite_cnt[c]);
            end
        end

        $display("checks done: %0d mismatches, %0d failures, %0d timeouts",
                 mism_cnt, fail_cnt, timeout_cnt);
        if (mism_cnt + fail_cnt + timeout_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hyperx_net.f ====
verilog/hyperx_pkg.sv
verilog/vertex_fifo.sv
verilog/rr_crossbar.sv
verilog/hyperx_node.sv
verilog/hyperx_net.sv
verif/hyperx_net_tb.sv

// ==== Bender.yml ====
package:
  name: hyperx_net

sources:
  - verilog/hyperx_pkg.sv
  - verilog/vertex_fifo.sv
  - verilog/rr_crossbar.sv
  - verilog/hyperx_node.sv
  - verilog/hyperx_net.sv
  - target: test
    files:
      - verif/hyperx_net_tb.sv

// ==== verif/hyperx_net_golden.txt ====
// columns: phase, source core, id, value, expected destination core
// value top byte is the source core, low bits a per-source sequence number
1 0 1000 00000001 0  1 1 1101 01000001 1  1 2 1202 02000001 2  1 3 1303 03000001 3
1 4 1404 04000001 4  1 5 1505 05000001 5  1 6 1606 06000001 6  1 7 1707 07000001 7
1 0 1009 00000002 1  1 1 110a 01000002 2  1 2 120b 02000002 3  1 3 130c 03000002 4
1 4 140d 04000002 5  1 5 150e 05000002 6  1 6 160f 06000002 7  1 7 1708 07000002 0
1 0 1002 00000003 2  1 1 1103 01000003 3  1 2 1204 02000003 4  1 3 1305 03000003 5
1 4 1406 04000003 6  1 5 1507 05000003 7  1 6 1600 06000003 0  1 7 1701 07000003 1
1 0 100b 00000004 3  1 1 110c 01000004 4  1 2 120d 02000004 5  1 3 130e 03000004 6
1 4 140f 04000004 7  1 5 1508 05000004 0  1 6 1609 06000004 1  1 7 170a 07000004 2
1 0 1004 00000005 4  1 1 1105 01000005 5  1 2 1206 02000005 6  1 3 1307 03000005 7
1 4 1400 04000005 0  1 5 1501 05000005 1  1 6 1602 06000005 2  1 7 1703 07000005 3
1 0 100d 00000006 5  1 1 110e 01000006 6  1 2 120f 02000006 7  1 3 1308 03000006 0
1 4 1409 04000006 1  1 5 150a 05000006 2  1 6 160b 06000006 3  1 7 170c 07000006 4
1 0 1006 00000007 6  1 1 1107 01000007 7  1 2 1200 02000007 0  1 3 1301 03000007 1
1 4 1402 04000007 2  1 5 1503 05000007 3  1 6 1604 06000007 4  1 7 1705 07000007 5
1 0 100f 00000008 7  1 1 1108 01000008 0  1 2 1209 02000008 1  1 3 130a 03000008 2
1 4 140b 04000008 3  1 5 150c 05000008 4  1 6 160d 06000008 5  1 7 170e 07000008 6
2 0 2005 00000009 5  2 1 2105 01000009 5  2 2 2205 02000009 5  2 3 2305 03000009 5
2 4 2405 04000009 5  2 5 2505 05000009 5  2 6 2605 06000009 5  2 7 2705 07000009 5
2 0 200d 0000000a 5  2 1 210d 0100000a 5  2 2 220d 0200000a 5  2 3 230d 0300000a 5
2 4 240d 0400000a 5  2 5 250d 0500000a 5  2 6 260d 0600000a 5  2 7 270d 0700000a 5
3 2 3206 0200000b 6  3 2 320e 0200000c 6  3 2 3206 0200000d 6  3 2 320e 0200000e 6
3 2 3206 0200000f 6  3 2 320e 02000010 6  3 2 3206 02000011 6  3 2 320e 02000012 6
3 2 3206 02000013 6  3 2 320e 02000014 6  3 2 3206 02000015 6  3 2 320e 02000016 6
3 2 3206 02000017 6  3 2 320e 02000018 6  3 2 3206 02000019 6  3 2 320e 0200001a 6
3 2 3206 0200001b 6  3 2 320e 0200001c 6  3 2 3206 0200001d 6  3 2 320e 0200001e 6
3 2 3206 0200001f 6  3 2 320e 02000020 6  3 2 3206 02000021 6  3 2 320e 02000022 6
4 3 4303 0300000b 3  4 3 430b 0300000c 3  4 3 4303 0300000d 3  4 3 430b 0300000e 3
f 0 0000 00000000 0
